//--- rtl/periph_xbar_pkg.sv
// Shared widths, region map constants and error response word for the cluster peripheral crossbar
package periph_xbar_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Bus widths
    ////////////////////////////////////////////////////////////////////////////

    // Master and slave address bus
    localparam int ADDR_WIDTH = 32;
    // Read and write data bus
    localparam int DATA_WIDTH = 32;

    ////////////////////////////////////////////////////////////////////////////
    // Region map
    ////////////////////////////////////////////////////////////////////////////

    // Address bits that select one 1 MB region
    localparam int REGION_MSB = 31;
    localparam int REGION_LSB = 20;
    localparam int REGION_W   = REGION_MSB - REGION_LSB + 1;

    // First region of the cluster space
    localparam logic [REGION_W-1:0] REGION_BASE = 12'h100;

    // Each cluster owns a block of four regions
    // Peripheral window sits at this offset inside the block
    localparam logic [REGION_W-1:0] PERIPH_OFFSET = 12'd2;

    // Width of the cluster identifier strap
    localparam int LOG_CLUSTER = 5;

    ////////////////////////////////////////////////////////////////////////////
    // Error responder
    ////////////////////////////////////////////////////////////////////////////

    // Read data for unmapped or out of range accesses
    localparam logic [DATA_WIDTH-1:0] ERR_RDATA = 32'hBADACCE5;

endpackage

//--- rtl/periph_addr_dec.sv
// Address decoder instantiated once per master that routes its request to one slave line
`timescale 1ns/100ps

module periph_addr_dec #(
    parameter int N_SLAVE   = 4,
    parameter int ROUTE_LSB = 16,
    parameter int ROUTE_MSB = 17,
    parameter bit ALIAS_EN  = 1'b1,
    parameter logic [periph_xbar_pkg::REGION_W-1:0] ALIAS_BASE = 12'h000
) (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic [periph_xbar_pkg::LOG_CLUSTER-1:0] cluster_id_i,
    // Master side
    input  logic                                   req_i,
    input  logic [periph_xbar_pkg::ADDR_WIDTH-1:0] addr_i,
    output logic                                   gnt_o,
    // Arbiter side, one line per slave
    output logic [N_SLAVE-1:0]                     dec_req_o,
    input  logic [N_SLAVE-1:0]                     slv_gnt_i
);

    localparam int ROUTE_W  = ROUTE_MSB - ROUTE_LSB + 1;
    localparam int REGION_W = periph_xbar_pkg::REGION_W;

    logic [REGION_W-1:0] region;
    logic [REGION_W-1:0] periph_region;
    logic [ROUTE_W-1:0]  route_idx;
    logic                cluster_hit;
    logic                alias_hit;
    logic                idx_ok;
    // Selected slave independent of the request level
    logic [N_SLAVE-1:0]  sel_oh;

    ////////////////////////////////////////////////////////////////////////////
    // Window match
    ////////////////////////////////////////////////////////////////////////////

    assign region    = addr_i[periph_xbar_pkg::REGION_MSB:periph_xbar_pkg::REGION_LSB];
    assign route_idx = addr_i[ROUTE_MSB:ROUTE_LSB];

    // Four regions per cluster with peripherals at a fixed offset inside
    assign periph_region = periph_xbar_pkg::REGION_BASE
                         + (REGION_W'(cluster_id_i) << 2)
                         + periph_xbar_pkg::PERIPH_OFFSET;

    assign cluster_hit = (region == periph_region);
    // Alias window sees the local cluster without knowing its id
    assign alias_hit   = ALIAS_EN && (region == ALIAS_BASE + periph_xbar_pkg::PERIPH_OFFSET);

    // Index of the last slave and above belongs to the error responder
    assign idx_ok = (cluster_hit || alias_hit) && (int'(route_idx) < N_SLAVE - 1);

    ////////////////////////////////////////////////////////////////////////////
    // Request routing and grant back-routing
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        sel_oh = '0;
        if (idx_ok)
        begin
            sel_oh[route_idx] = 1'b1;
        end
        else
        begin
            sel_oh[N_SLAVE-1] = 1'b1;
        end
    end

    assign dec_req_o = sel_oh & {N_SLAVE{req_i}};
    // Grant of the selected line only
    assign gnt_o     = |(sel_oh & slv_gnt_i);

    // Arbiters grant this master only on the line it requests
    assert property (@(posedge clk_i) disable iff (!rst_n_i) (slv_gnt_i & ~dec_req_o) == '0);

endmodule

//--- rtl/periph_rr_arb.sv
// Round-robin arbiter instantiated once per slave that merges all master requests onto its port
`timescale 1ns/100ps

module periph_rr_arb #(
    parameter int N_MASTER = 2
) (
    input  logic                                            clk_i,
    input  logic                                            rst_n_i,
    // Routed master requests and their fields with master 0 in the low bits
    input  logic [N_MASTER-1:0]                             req_i,
    input  logic [N_MASTER*periph_xbar_pkg::ADDR_WIDTH-1:0] addr_i,
    input  logic [N_MASTER-1:0]                             we_i,
    input  logic [N_MASTER*periph_xbar_pkg::DATA_WIDTH-1:0] wdata_i,
    // Slave port
    output logic                                            s_req_o,
    output logic [periph_xbar_pkg::ADDR_WIDTH-1:0]          s_addr_o,
    output logic                                            s_we_o,
    output logic [periph_xbar_pkg::DATA_WIDTH-1:0]          s_wdata_o,
    input  logic                                            s_gnt_i,
    // Per-master grants back to the decoders
    output logic [N_MASTER-1:0]                             gnt_o,
    // Handshake and winner for the response router
    output logic                                            hs_o,
    output logic [$clog2(N_MASTER)-1:0]                     owner_o
);

    localparam int LOG_M = $clog2(N_MASTER);
    localparam int AW    = periph_xbar_pkg::ADDR_WIDTH;
    localparam int DW    = periph_xbar_pkg::DATA_WIDTH;

    // Highest priority master for the next decision
    logic [LOG_M-1:0] ptr_q;
    logic [LOG_M-1:0] winner;
    logic             found;
    int               cand;

    ////////////////////////////////////////////////////////////////////////////
    // Winner search
    ////////////////////////////////////////////////////////////////////////////

    // First requester at or after the pointer with wrap-around
    always_comb
    begin
        found  = 1'b0;
        winner = '0;
        cand   = 0;
        for (int i = 0; i < N_MASTER; i++)
        begin
            cand = (int'(ptr_q) + i) % N_MASTER;
            if (!found && req_i[cand])
            begin
                found  = 1'b1;
                winner = LOG_M'(cand);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slave port mux and grant return
    ////////////////////////////////////////////////////////////////////////////

    assign s_req_o   = found;
    assign s_addr_o  = addr_i[winner*AW +: AW];
    assign s_we_o    = we_i[winner];
    assign s_wdata_o = wdata_i[winner*DW +: DW];

    always_comb
    begin
        gnt_o         = '0;
        gnt_o[winner] = found & s_gnt_i;
    end

    assign hs_o    = found & s_gnt_i;
    assign owner_o = winner;

    // Pointer moves past the winner on each accepted request
    // Back-pressure leaves it in place
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            ptr_q <= '0;
        end
        else if (hs_o)
        begin
            ptr_q <= (int'(winner) == N_MASTER - 1) ? '0 : winner + 1'b1;
        end
    end

    // A master left waiting at a handshake is served before the winner again
    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (hs_o && ((req_i & ~gnt_o) != '0)) |=> !(hs_o && (owner_o == $past(owner_o))));

endmodule

//--- rtl/periph_resp_route.sv
// Response router, remembers who owns each slave handshake and steers read data back
`timescale 1ns/100ps

module periph_resp_route #(
    parameter int N_MASTER = 2,
    parameter int N_SLAVE  = 4
) (
    input  logic                                            clk_i,
    input  logic                                            rst_n_i,
    // Handshakes and winners from the arbiters
    input  logic [N_SLAVE-1:0]                              hs_i,
    input  logic [N_SLAVE*$clog2(N_MASTER)-1:0]             owner_i,
    // Slave responses
    input  logic [N_SLAVE-1:0]                              s_r_valid_i,
    input  logic [N_SLAVE*periph_xbar_pkg::DATA_WIDTH-1:0]  s_r_rdata_i,
    // Master responses
    output logic [N_MASTER-1:0]                             m_r_valid_o,
    output logic [N_MASTER*periph_xbar_pkg::DATA_WIDTH-1:0] m_r_rdata_o
);

    localparam int LOG_M = $clog2(N_MASTER);
    localparam int DW    = periph_xbar_pkg::DATA_WIDTH;

    // One outstanding request per slave, answered next cycle
    logic [N_SLAVE-1:0]            pend_q;
    logic [N_SLAVE-1:0][LOG_M-1:0] owner_q;

    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            pend_q <= '0;
        end
        else
        begin
            pend_q <= hs_i;
        end
    end

    // Owner only matters while pending
    always_ff @(posedge clk_i)
    begin
        owner_q <= owner_i;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Steering
    ////////////////////////////////////////////////////////////////////////////

    // A master has one request in flight, so at most one slave matches it
    always_comb
    begin
        m_r_valid_o = '0;
        m_r_rdata_o = '0;
        for (int s = 0; s < N_SLAVE; s++)
        begin
            for (int m = 0; m < N_MASTER; m++)
            begin
                if (pend_q[s] && s_r_valid_i[s] && (owner_q[s] == LOG_M'(m)))
                begin
                    m_r_valid_o[m]            = 1'b1;
                    m_r_rdata_o[m*DW +: DW]   = s_r_rdata_i[s*DW +: DW];
                end
            end
        end
    end

    // Slaves answer only the cycle after their own handshake
    assert property (@(posedge clk_i) disable iff (!rst_n_i) (s_r_valid_i & ~pend_q) == '0);

endmodule

//--- rtl/periph_err_slave.sv
// Default slave for unmapped accesses, accepts at once and answers with the error word
`timescale 1ns/100ps

module periph_err_slave (
    input  logic                                   clk_i,
    input  logic                                   rst_n_i,
    input  logic                                   req_i,
    output logic                                   gnt_o,
    output logic                                   r_valid_o,
    output logic [periph_xbar_pkg::DATA_WIDTH-1:0] r_rdata_o
);

    logic r_valid_q;

    // Never back-pressures
    assign gnt_o = req_i;

    // Response one cycle after each accepted request
    always_ff @(posedge clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            r_valid_q <= 1'b0;
        end
        else
        begin
            r_valid_q <= req_i;
        end
    end

    assign r_valid_o = r_valid_q;
    // Same word for reads and writes, writes ignore it
    assign r_rdata_o = periph_xbar_pkg::ERR_RDATA;

endmodule

//--- rtl/periph_xbar_top.sv
// Cluster peripheral crossbar top, connects master decoders, slave arbiters and response routing
`timescale 1ns/100ps

module periph_xbar_top #(
    parameter int N_MASTER  = 2,
    parameter int N_SLAVE   = 4,
    parameter int ROUTE_LSB = 16,
    parameter int ROUTE_MSB = 17,
    parameter bit ALIAS_EN  = 1'b1,
    parameter logic [periph_xbar_pkg::REGION_W-1:0] ALIAS_BASE = 12'h000
) (
    input  logic                                                clk_i,
    input  logic                                                rst_n_i,
    input  logic [periph_xbar_pkg::LOG_CLUSTER-1:0]             cluster_id_i,
    // Master ports
    input  logic [N_MASTER-1:0]                                 m_req_i,
    input  logic [N_MASTER*periph_xbar_pkg::ADDR_WIDTH-1:0]     m_addr_i,
    input  logic [N_MASTER-1:0]                                 m_we_i,
    input  logic [N_MASTER*periph_xbar_pkg::DATA_WIDTH-1:0]     m_wdata_i,
    output logic [N_MASTER-1:0]                                 m_gnt_o,
    output logic [N_MASTER-1:0]                                 m_r_valid_o,
    output logic [N_MASTER*periph_xbar_pkg::DATA_WIDTH-1:0]     m_r_rdata_o,
    // External slave ports, error slave excluded
    output logic [N_SLAVE-2:0]                                  s_req_o,
    output logic [(N_SLAVE-1)*periph_xbar_pkg::ADDR_WIDTH-1:0]  s_addr_o,
    output logic [N_SLAVE-2:0]                                  s_we_o,
    output logic [(N_SLAVE-1)*periph_xbar_pkg::DATA_WIDTH-1:0]  s_wdata_o,
    input  logic [N_SLAVE-2:0]                                  s_gnt_i,
    input  logic [N_SLAVE-2:0]                                  s_r_valid_i,
    input  logic [(N_SLAVE-1)*periph_xbar_pkg::DATA_WIDTH-1:0]  s_r_rdata_i
);

    localparam int LOG_M = $clog2(N_MASTER);
    localparam int AW    = periph_xbar_pkg::ADDR_WIDTH;
    localparam int DW    = periph_xbar_pkg::DATA_WIDTH;

    // Decoder outputs by master, and the same bits regrouped by slave
    logic [N_MASTER-1:0][N_SLAVE-1:0] dec_req;
    logic [N_SLAVE-1:0][N_MASTER-1:0] arb_req;
    // Arbiter grants by slave, and regrouped by master
    logic [N_SLAVE-1:0][N_MASTER-1:0] arb_gnt;
    logic [N_MASTER-1:0][N_SLAVE-1:0] slv_gnt;

    // All slave ports, error slave on the top index
    logic [N_SLAVE-1:0]              sl_req;
    logic [N_SLAVE*AW-1:0]           sl_addr;
    logic [N_SLAVE-1:0]              sl_we;
    logic [N_SLAVE*DW-1:0]           sl_wdata;
    logic [N_SLAVE-1:0]              sl_gnt;
    logic [N_SLAVE-1:0]              sl_r_valid;
    logic [N_SLAVE*DW-1:0]           sl_r_rdata;
    logic [N_SLAVE-1:0]              hs;
    logic [N_SLAVE-1:0][LOG_M-1:0]   owner;

    logic                            err_gnt;
    logic                            err_r_valid;
    logic [DW-1:0]                   err_r_rdata;

    ////////////////////////////////////////////////////////////////////////////
    // Request side
    ////////////////////////////////////////////////////////////////////////////

    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_dec
        periph_addr_dec #(
            .N_SLAVE    (N_SLAVE),
            .ROUTE_LSB  (ROUTE_LSB),
            .ROUTE_MSB  (ROUTE_MSB),
            .ALIAS_EN   (ALIAS_EN),
            .ALIAS_BASE (ALIAS_BASE)
        ) dec_i (
            .clk_i        (clk_i),
            .rst_n_i      (rst_n_i),
            .cluster_id_i (cluster_id_i),
            .req_i        (m_req_i[m]),
            .addr_i       (m_addr_i[m*AW +: AW]),
            .gnt_o        (m_gnt_o[m]),
            .dec_req_o    (dec_req[m]),
            .slv_gnt_i    (slv_gnt[m])
        );

        // Transpose between master and slave views
        for (genvar s = 0; s < N_SLAVE; s++)
        begin : g_xpose
            assign arb_req[s][m] = dec_req[m][s];
            assign slv_gnt[m][s] = arb_gnt[s][m];
        end
    end

    for (genvar s = 0; s < N_SLAVE; s++)
    begin : g_arb
        periph_rr_arb #(
            .N_MASTER (N_MASTER)
        ) arb_i (
            .clk_i     (clk_i),
            .rst_n_i   (rst_n_i),
            .req_i     (arb_req[s]),
            .addr_i    (m_addr_i),
            .we_i      (m_we_i),
            .wdata_i   (m_wdata_i),
            .s_req_o   (sl_req[s]),
            .s_addr_o  (sl_addr[s*AW +: AW]),
            .s_we_o    (sl_we[s]),
            .s_wdata_o (sl_wdata[s*DW +: DW]),
            .s_gnt_i   (sl_gnt[s]),
            .gnt_o     (arb_gnt[s]),
            .hs_o      (hs[s]),
            .owner_o   (owner[s])
        );
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slave side
    ////////////////////////////////////////////////////////////////////////////

    assign s_req_o    = sl_req[N_SLAVE-2:0];
    assign s_addr_o   = sl_addr[(N_SLAVE-1)*AW-1:0];
    assign s_we_o     = sl_we[N_SLAVE-2:0];
    assign s_wdata_o  = sl_wdata[(N_SLAVE-1)*DW-1:0];
    assign sl_gnt     = {err_gnt, s_gnt_i};
    assign sl_r_valid = {err_r_valid, s_r_valid_i};
    assign sl_r_rdata = {err_r_rdata, s_r_rdata_i};

    // Unmapped accesses end here
    periph_err_slave err_slave_i (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (sl_req[N_SLAVE-1]),
        .gnt_o     (err_gnt),
        .r_valid_o (err_r_valid),
        .r_rdata_o (err_r_rdata)
    );

    periph_resp_route #(
        .N_MASTER (N_MASTER),
        .N_SLAVE  (N_SLAVE)
    ) resp_route_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .hs_i        (hs),
        .owner_i     (owner),
        .s_r_valid_i (sl_r_valid),
        .s_r_rdata_i (sl_r_rdata),
        .m_r_valid_o (m_r_valid_o),
        .m_r_rdata_o (m_r_rdata_o)
    );

endmodule

//--- dv/periph_xbar_tb.sv
// Directed testbench that drives the peripheral crossbar top with external slave models
`timescale 1ns/100ps

module periph_xbar_tb;

    localparam int PERIOD      = 40;
    localparam int QTR         = PERIOD / 4;
    localparam int SEED        = 92974;
    localparam int GNT_TIMEOUT = 50;
    localparam logic [11:0] WIN   = 12'h10E;
    localparam logic [11:0] ALIAS = 12'h002;

    logic        clk;
    logic        rst_n;
    logic [1:0]  m_req;
    logic [1:0]  m_we;
    logic [1:0]  m_gnt;
    logic [1:0]  m_r_valid;
    logic [63:0] m_addr;
    logic [63:0] m_wdata;
    logic [63:0] m_r_rdata;
    logic [2:0]  s_req;
    logic [2:0]  s_we;
    logic [2:0]  s_gnt;
    logic [2:0]  s_r_valid;
    logic [2:0]  gnt_en;
    logic [95:0] s_addr;
    logic [95:0] s_wdata;
    logic [95:0] s_r_rdata;
    // Slave model state with handshake counters and written words keyed by slave and address
    int          hs_cnt [3];
    logic [31:0] wr_mem [logic [33:0]];

    periph_xbar_top dut_i (
        .clk_i        (clk),
        .rst_n_i      (rst_n),
        .cluster_id_i (5'd3),
        .m_req_i      (m_req),
        .m_addr_i     (m_addr),
        .m_we_i       (m_we),
        .m_wdata_i    (m_wdata),
        .m_gnt_o      (m_gnt),
        .m_r_valid_o  (m_r_valid),
        .m_r_rdata_o  (m_r_rdata),
        .s_req_o      (s_req),
        .s_addr_o     (s_addr),
        .s_we_o       (s_we),
        .s_wdata_o    (s_wdata),
        .s_gnt_i      (s_gnt),
        .s_r_valid_i  (s_r_valid),
        .s_r_rdata_i  (s_r_rdata)
    );

    initial
    begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // External slave models
    ////////////////////////////////////////////////////////////////////////////

    // Grant follows the per-slave enable and back-pressures when cleared
    assign s_gnt = gnt_en;

    // Read word is the address xor the slave index one cycle after the handshake
    always @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            s_r_valid <= '0;
            s_r_rdata <= '0;
            for (int k = 0; k < 3; k++)
                hs_cnt[k] <= 0;
        end
        else
        begin
            for (int k = 0; k < 3; k++)
            begin
                s_r_valid[k] <= s_req[k] & s_gnt[k];
                if (s_req[k] && s_gnt[k])
                begin
                    s_r_rdata[k*32 +: 32] <= s_addr[k*32 +: 32] ^ k;
                    hs_cnt[k]             <= hs_cnt[k] + 1;
                    if (s_we[k])
                        wr_mem[{2'(k), s_addr[k*32 +: 32]}] = s_wdata[k*32 +: 32];
                end
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_eq(input logic [31:0] act, input logic [31:0] exp, input string what);
        if (act !== exp)
            stop_run($sformatf("ERROR @%0t: %s, got 0x%08h expected 0x%08h",
                               $time, what, act, exp));
    endtask

    // Region in 31:20 and routing index in 17:16 with a random word offset elsewhere
    function automatic logic [31:0] make_addr(input logic [11:0] region, input int idx);
        logic [31:0] a;
        a          = $urandom & 32'h000C_FFFC;
        a[31:20]   = region;
        a[17:16]   = 2'(idx);
        return a;
    endfunction

    // Sampled a quarter period after each falling edge
    task automatic wait_gnt(input int m, output int waited);
        waited = 0;
        while (m_gnt[m] !== 1'b1)
        begin
            @(negedge clk);
            #(QTR);
            waited++;
            if (waited > GNT_TIMEOUT)
                stop_run($sformatf("No grant for master %0d after %0d cycles", m, waited));
        end
    endtask

    // One access by one master where slave index 3 is the error responder
    task automatic single_access(input int m, input logic [31:0] addr, input logic we,
                                 input int slv);
        logic [31:0] wdata;
        logic [31:0] exp_data;
        int          waited;
        wdata = $urandom;
        @(negedge clk);
        m_req[m]            = 1'b1;
        m_we[m]             = we;
        m_addr[m*32 +: 32]  = addr;
        m_wdata[m*32 +: 32] = wdata;
        #(QTR);
        check_eq(32'(s_req), (slv < 3) ? 32'(1 << slv) : 32'd0, "decoded slave request");
        wait_gnt(m, waited);
        check_eq(waited, 0, "grant in request cycle");
        if (slv < 3)
            check_eq(s_addr[slv*32 +: 32], addr, "slave address");
        @(negedge clk);
        m_req[m] = 1'b0;
        #(QTR);
        check_eq(32'(m_r_valid), 32'(1 << m), "response one cycle after grant");
        exp_data = (slv < 3) ? (addr ^ slv) : periph_xbar_pkg::ERR_RDATA;
        if (!we)
            check_eq(m_r_rdata[m*32 +: 32], exp_data, "read data");
        else if (slv < 3)
            check_eq(wr_mem[{2'(slv), addr}], wdata, "written word at slave");
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Directed tests
    ////////////////////////////////////////////////////////////////////////////

    task automatic idle_test();
        for (int n = 0; n < 4; n++)
        begin
            @(negedge clk);
            #(QTR);
            check_eq(32'(s_req), 0, "idle slave request");
            check_eq(32'(m_gnt), 0, "idle grant");
            check_eq(32'(m_r_valid), 0, "idle response");
        end
    endtask

    // Reads and writes on every external slave through the given window
    task automatic window_test(input logic [11:0] region);
        for (int m = 0; m < 2; m++)
            for (int s = 0; s < 3; s++)
            begin
                single_access(m, make_addr(region, s), 1'b0, s);
                single_access(m, make_addr(region, s), 1'b1, s);
            end
    endtask

    // Accesses outside the window with index 3 and in the window of cluster 2
    task automatic error_route_test();
        for (int m = 0; m < 2; m++)
        begin
            single_access(m, make_addr(12'h200, 1), 1'b0, 3);
            single_access(m, make_addr(WIN, 3), 1'b0, 3);
            single_access(m, make_addr(12'h10A, 0), 1'b0, 3);
            single_access(m, make_addr(12'h10A, 2), 1'b1, 3);
        end
    endtask

    // Both masters hammer slave 1 and the grants alternate
    task automatic contention_test();
        logic [31:0] a [2];
        logic [31:0] prev_addr;
        int          prev;
        int          win;
        prev      = -1;
        prev_addr = '0;
        @(negedge clk);
        for (int m = 0; m < 2; m++)
        begin
            a[m]               = make_addr(WIN, 1);
            m_addr[m*32 +: 32] = a[m];
        end
        m_we  = 2'b00;
        m_req = 2'b11;
        #(QTR);
        for (int n = 0; n < 8; n++)
        begin
            check_eq($countones(m_gnt), 1, "single grant under contention");
            check_eq(32'(s_req), 32'h2, "shared slave request");
            win = m_gnt[1] ? 1 : 0;
            if (prev >= 0)
            begin
                check_eq(win, 1 - prev, "grant alternation");
                check_eq(32'(m_r_valid), 32'(1 << prev), "response to previous winner");
                check_eq(m_r_rdata[prev*32 +: 32], prev_addr ^ 1, "previous winner data");
            end
            prev      = win;
            prev_addr = a[win];
            @(negedge clk);
            a[win]               = make_addr(WIN, 1);
            m_addr[win*32 +: 32] = a[win];
            if (n == 7)
                m_req = 2'b00;
            #(QTR);
        end
        check_eq(32'(m_r_valid), 32'(1 << prev), "last response");
        check_eq(m_r_rdata[prev*32 +: 32], prev_addr ^ 1, "last response data");
    endtask

    // Slave 0 stalls master 0 while master 1 is served by slave 2
    task automatic backpressure_test();
        logic [31:0] a0;
        logic [31:0] a1;
        int          hold;
        int          base;
        int          waited;
        hold = 2 + ($urandom % 6);
        a0   = make_addr(WIN, 0);
        a1   = make_addr(WIN, 2);
        @(negedge clk);
        base      = hs_cnt[0];
        gnt_en[0] = 1'b0;
        m_we      = 2'b00;
        m_addr    = {a1, a0};
        m_req     = 2'b11;
        #(QTR);
        for (int n = 0; n < hold; n++)
        begin
            check_eq(32'(m_gnt[0]), 0, "stalled grant");
            check_eq(32'(s_req[0]), 1, "held slave request");
            check_eq(s_addr[31:0], a0, "held slave address");
            check_eq(32'(m_r_valid[0]), 0, "no response while stalled");
            if (n == 0)
                check_eq(32'(m_gnt[1]), 1, "parallel grant on slave 2");
            if (n == 1)
                check_eq(m_r_valid[1] ? m_r_rdata[63:32] : 32'd0, a1 ^ 2, "parallel response");
            @(negedge clk);
            if (n == 0)
                m_req[1] = 1'b0;
            if (n == hold - 1)
                gnt_en[0] = 1'b1;
            #(QTR);
        end
        wait_gnt(0, waited);
        check_eq(waited, 0, "grant in release cycle");
        @(negedge clk);
        m_req[0] = 1'b0;
        #(QTR);
        check_eq(32'(m_r_valid), 32'h1, "response after release");
        check_eq(m_r_rdata[31:0], a0, "released read data");
        @(negedge clk);
        #(QTR);
        check_eq(32'(m_r_valid), 0, "single response after release");
        check_eq(hs_cnt[0], base + 1, "single handshake after release");
    endtask

    initial
    begin
        void'($urandom(SEED));
        rst_n   = 1'b0;
        m_req   = '0;
        m_we    = '0;
        m_addr  = '0;
        m_wdata = '0;
        gnt_en  = 3'b111;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        idle_test();
        window_test(WIN);
        error_route_test();
        window_test(ALIAS);
        contention_test();
        backpressure_test();
        $display("Regression passed");
        $finish;
    end

endmodule

//--- tb.f
rtl/periph_xbar_pkg.sv
rtl/periph_addr_dec.sv
rtl/periph_rr_arb.sv
rtl/periph_resp_route.sv
rtl/periph_err_slave.sv
rtl/periph_xbar_top.sv
dv/periph_xbar_tb.sv

//--- Makefile
# Verilator build and regression run for the peripheral crossbar

SIM := obj_dir/Vperiph_xbar_tb
LOG := sim.log

all: run

$(SIM): tb.f $(wildcard rtl/*.sv) $(wildcard dv/*.sv)
	verilator --binary --timing --assert -j 0 --top-module periph_xbar_tb -f tb.f -o Vperiph_xbar_tb

run: $(SIM)
	$(SIM) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

.PHONY: all run clean
